// ==== filelist.f ====
design/cpuPkg.sv
design/alu.sv
design/registerFile.sv
design/memPort.sv
design/datapath.sv
design/controlFsm.sv
design/stackCpu.sv
testbench/stackCpu_assert.sv
testbench/tb_stackCpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_stackCpu -f filelist.f -o simStackCpu

./obj_dir/simStackCpu | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
	exit 1
fi
exit 0

// ==== testbench/tb_stackCpu.sv ====
`timescale 1ns/1ps

module tb_stackCpu;
	import cpuPkg::*;

	logic clk;
	logic reset;
	logic memReq;
	logic memWrite;
	logic memAck;
	word memAddr;
	word memWdata;
	word memRdata;

	integer seed = 32'h11d16d16;
	word mem [1024];
	logic [1:0] memPhase;
	logic [2:0] delayCnt;
	logic ackPrev;

	// Reference model state
	word refMem [1024];
	word refRegs [regCount];
	word refPc;
	word refSp;
	flagsT refFlags;
	word expAddr [$];
	logic expWr [$];
	word expData [$];
	word prog [$];
	word stackData [$];
	word haltAddr;
	bit haltSeen;
	bit aborted;
	int accessCount;
	int checkCount;
	int testErrors;
	int totalErrors;
	int testCount;

	stackCpu u_stackCpu (
		.clk(clk),
		.reset(reset),
		.memReq(memReq),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memAck(memAck),
		.memRdata(memRdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////
	// Memory model with random ack delays
	////////////////////////////////////////////////////////////////////
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			memAck <= 1'b0;
			memPhase <= 2'd0;
			delayCnt <= 3'd0;
		end else begin
			case (memPhase)
				2'd0: if (memReq) begin
					delayCnt <= 3'($unsigned($random(seed)) % 5);
					memPhase <= 2'd1;
				end
				2'd1: if (delayCnt == 3'd0) begin
					memAck <= 1'b1;
					memRdata <= mem[memAddr[9:0]];
					if (memWrite) mem[memAddr[9:0]] <= memWdata;
					memPhase <= 2'd2;
				end else delayCnt <= delayCnt - 3'd1;
				2'd2: if (!memReq) begin
					delayCnt <= 3'($unsigned($random(seed)) % 5);
					memPhase <= 2'd3;
				end
				default: if (delayCnt == 3'd0) begin
					memAck <= 1'b0;
					memPhase <= 2'd0;
				end else delayCnt <= delayCnt - 3'd1;
			endcase
		end
	end

	function automatic word encStack(stackOpT op, logic [1:0] f, regIndex r);
		return {4'hF, op, f, r, 5'b0};
	endfunction

	function automatic word encBranch(logic [3:0] code, logic [11:0] off);
		return {code, off};
	endfunction

	function automatic void expectAccess(word a, logic w, word d);
		expAddr.push_back(a);
		expWr.push_back(w);
		expData.push_back(d);
	endfunction

	function automatic bit condHolds(logic [3:0] code);
		case (code)
			4'h1: return 1'b1;
			4'h2: return refFlags.carry;
			4'h3: return !refFlags.carry;
			4'h4: return refFlags.zero;
			4'h5: return !refFlags.zero;
			4'h6: return refFlags.overflow;
			4'h7: return !refFlags.overflow;
			4'h8: return refFlags.sign;
			default: return !refFlags.sign;
		endcase
	endfunction

	// One instruction of the ISA, queues the accesses it makes
	function automatic void stepIsa();
		word ir;
		word off;
		word x;
		word y;
		word r;
		logic [16:0] full;
		int sum;
		int idx;
		logic carry;
		logic ovf;
		ir = refMem[refPc[9:0]];
		expectAccess(refPc, 1'b0, '0);
		refPc = refPc + 16'd1;
		off = {{4{ir[11]}}, ir[11:0]};
		idx = int'(ir[7:5]);
		if (ir[15:12] == 4'hF) begin
			if (ir[11:10] == 2'd0) begin
				refSp = refSp - 16'd1;
				expectAccess(refSp, 1'b1, refRegs[idx]);
				refMem[refSp[9:0]] = refRegs[idx];
			end else begin
				expectAccess(refSp, 1'b0, '0);
				y = refMem[refSp[9:0]];
				refSp = refSp + 16'd1;
				if (ir[11:10] == 2'd1) refRegs[idx] = y;
				else if (ir[11:10] == 2'd3) refPc = y;
				else begin
					x = refRegs[idx];
					carry = 1'b0;
					ovf = 1'b0;
					case (ir[9:8])
						2'd0: begin
							full = {1'b0, x} + {1'b0, y};
							sum = $signed(x) + $signed(y);
							r = full[15:0];
							carry = full[16];
							ovf = (sum > 32767) || (sum < -32768);
						end
						2'd1: r = 16'd0 - y;
						2'd2: r = x | y;
						default: r = ~y;
					endcase
					refRegs[idx] = r;
					refFlags = {r[15], ovf, carry, r == 16'd0};
				end
			end
		end else if (ir[15:12] == 4'hA) begin
			refSp = refSp - 16'd1;
			expectAccess(refSp, 1'b1, refPc);
			refMem[refSp[9:0]] = refPc;
			refPc = refPc + off;
		end else if (ir[15:12] >= 4'h1 && ir[15:12] <= 4'h9) begin
			if (condHolds(ir[15:12])) refPc = refPc + off;
		end
	endfunction

	task automatic checkWord(input string name, input word got, input word exp);
		checkCount++;
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkWrite(input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			$display("Fail memWrite: got %h expected %h", got, exp);
			testErrors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Compare process, one check per access at the rise of memAck
	////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (reset) begin
			ackPrev <= 1'b0;
		end else begin
			ackPrev <= memAck;
			if (memAck && !ackPrev) begin
				if (expAddr.size() == 0) stepIsa();
				checkWord("memAddr", memAddr, expAddr[0]);
				checkWrite(memWrite, expWr[0]);
				if (expWr[0]) checkWord("memWdata", memWdata, expData[0]);
				if (!memWrite && memAddr == haltAddr) haltSeen = 1'b1;
				void'(expAddr.pop_front());
				void'(expWr.pop_front());
				void'(expData.pop_front());
				accessCount++;
			end
		end
	end

	task automatic loadImage();
		word fill;
		for (int i = 0; i < 1024; i++) begin
			fill = {4'hE, 2'b00, 10'(i)};
			mem[i] <= fill;
			refMem[i] = fill;
		end
		foreach (prog[i]) begin
			mem[i] <= prog[i];
			refMem[i] = prog[i];
		end
		foreach (stackData[i]) begin
			mem[256 + i] <= stackData[i];
			refMem[256 + i] = stackData[i];
		end
	endtask

	task automatic runTest(input string name, input word halt);
		int idleCycles;
		int lastCount;
		bit lowInReset;
		testErrors = 0;
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		loadImage();
		expAddr.delete();
		expWr.delete();
		expData.delete();
		haltAddr = halt;
		haltSeen = 1'b0;
		refPc = resetPc;
		refSp = stackTop;
		refFlags = '0;
		foreach (refRegs[i]) refRegs[i] = '0;
		lowInReset = 1'b1;
		repeat (2) begin
			@(posedge clk);
			if (memReq) lowInReset = 1'b0;
		end
		reset <= 1'b0;
		if (!lowInReset) begin
			$display("memReq was high while reset was held");
			testErrors++;
		end
		idleCycles = 0;
		lastCount = accessCount;
		while (!haltSeen && idleCycles < 200) begin
			@(posedge clk);
			if (accessCount != lastCount) idleCycles = 0;
			else idleCycles++;
			lastCount = accessCount;
		end
		if (!haltSeen) begin
			$display("%s timed out, no memory access for 200 cycles", name);
			testErrors++;
			aborted = 1'b1;
		end
		$display("Test %0d %s: %0d errors", testCount + 1, name, testErrors);
		testCount++;
		totalErrors += testErrors;
	endtask

	initial begin
		reset <= 1'b1;
		memAck <= 1'b0;
		memRdata <= '0;
		aborted = 1'b0;
		// Reset state and first fetch
		prog = '{encBranch(4'h1, 12'hFFF)};
		stackData.delete();
		runTest("reset fetch", 16'h0000);
		prog = '{encStack(stPop, 2'd0, 3'd1), encStack(stPush, 2'd0, 3'd1),
			encStack(stPop, 2'd0, 3'd2), encStack(stPush, 2'd0, 3'd2),
			encBranch(4'h1, 12'hFFF)};
		stackData = '{16'h1234};
		if (!aborted) runTest("push pop", 16'h0004);
		prog = '{encStack(stPop, 2'd0, 3'd1)};
		for (int f = 0; f < 4; f++) begin
			prog.push_back(encStack(stAluStack, 2'(f), 3'd1));
			prog.push_back(encStack(stPush, 2'd0, 3'd1));
			// Pop the pushed result so the next operation gets a fresh operand
			prog.push_back(encStack(stPop, 2'd0, 3'd2));
		end
		prog.push_back(encBranch(4'h1, 12'hFFF));
		stackData = '{16'h1234, 16'h0F0F, 16'h0005, 16'h0006, 16'h00FF};
		if (!aborted) runTest("stack alu", 16'h000D);
		// Call to 2, ret back to the halt at 1
		prog = '{encBranch(4'hA, 12'h001), encBranch(4'h1, 12'hFFF),
			encStack(stRet, 2'd0, 3'd0)};
		stackData.delete();
		if (!aborted) runTest("call ret", 16'h0001);
		prog.delete();
		for (int s = 0; s < 2; s++) begin
			prog.push_back(encStack(stPop, 2'd0, 3'(s + 1)));
			prog.push_back(encStack(stAluStack, 2'd0, 3'(s + 1)));
			for (int c = 1; c < 10; c++) begin
				prog.push_back(encBranch(4'(c), 12'h001));
				prog.push_back(16'h0000);
			end
		end
		prog.push_back(encBranch(4'h1, 12'hFFF));
		stackData = '{16'hFFFF, 16'h0001, 16'h7FFF, 16'h0001};
		if (!aborted) runTest("branches", 16'(prog.size() - 1));
		prog = '{encStack(stPop, 2'd0, 3'd4), encStack(stAluStack, 2'd3, 3'd5),
			encStack(stPush, 2'd0, 3'd5), encStack(stPush, 2'd0, 3'd4),
			encBranch(4'hA, 12'h001), encBranch(4'h1, 12'hFFF),
			encStack(stRet, 2'd0, 3'd0)};
		stackData = '{16'hA5A5, 16'h0F0F};
		if (!aborted) runTest("mixed random delays", 16'h0005);
		$display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, totalErrors);
		if (totalErrors == 0 && !aborted) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== testbench/stackCpu_assert.sv ====
`timescale 1ns/1ps

module stackCpu_assert (
	input logic clk,
	input logic reset,
	input logic memReq,
	input logic memAck,
	input cpuPkg::word memAddr
);
	import cpuPkg::*;

	// New request only once the memory has released ack
	assert property (@(posedge clk) disable iff (reset) $rose(memReq) |-> !memAck)
		else $error("memReq rose while memAck was high");

	assert property (@(posedge clk) disable iff (reset)
		memReq && $past(memReq) |-> $stable(memAddr))
		else $error("memAddr changed during a request");

	assert property (@(posedge clk) reset |-> !memReq)
		else $error("memReq high during reset");

endmodule

bind memPort stackCpu_assert u_stackCpuAssert (
	.clk(clk),
	.reset(reset),
	.memReq(memReq),
	.memAck(memAck),
	.memAddr(memAddr)
);

// ==== design/stackCpu.sv ====
`timescale 1ns/1ps

module stackCpu (
	input logic clk,
	input logic reset,
	output logic memReq,
	output logic memWrite,
	output cpuPkg::word memAddr,
	output cpuPkg::word memWdata,
	input logic memAck,
	input cpuPkg::word memRdata
);
	import cpuPkg::*;

	logic irLoad;
	logic pcLoad;
	logic spLoad;
	logic regLoad;
	logic yLoad;
	logic flagLoad;
	logic addrSel;
	logic memStart;
	logic startWrite;
	logic memDone;
	logic [1:0] aluField;
	aluOpT aluOp;
	xSelT xSel;
	ySelT ySel;
	opcodeT opcode;
	stackOpT stackOp;
	flagsT flags;
	word busAddr;
	word busWdata;
	word rdata;

	datapath u_datapath (
		.clk(clk),
		.reset(reset),
		.irLoad(irLoad),
		.pcLoad(pcLoad),
		.spLoad(spLoad),
		.regLoad(regLoad),
		.yLoad(yLoad),
		.flagLoad(flagLoad),
		.aluOp(aluOp),
		.xSel(xSel),
		.ySel(ySel),
		.addrSel(addrSel),
		.memData(rdata),
		.memAddr(busAddr),
		.memWdata(busWdata),
		.opcode(opcode),
		.stackOp(stackOp),
		.aluField(aluField),
		.flags(flags)
	);

	controlFsm u_controlFsm (
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.stackOp(stackOp),
		.aluField(aluField),
		.flags(flags),
		.memDone(memDone),
		.memStart(memStart),
		.memWrite(startWrite),
		.irLoad(irLoad),
		.pcLoad(pcLoad),
		.spLoad(spLoad),
		.regLoad(regLoad),
		.yLoad(yLoad),
		.flagLoad(flagLoad),
		.aluOp(aluOp),
		.xSel(xSel),
		.ySel(ySel),
		.addrSel(addrSel)
	);

	// External bus master
	memPort u_memPort (
		.clk(clk),
		.reset(reset),
		.memStart(memStart),
		.memWrite(startWrite),
		.addr(busAddr),
		.wdata(busWdata),
		.memAck(memAck),
		.memRdata(memRdata),
		.memReq(memReq),
		.memWriteOut(memWrite),
		.memDone(memDone),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.rdata(rdata)
	);

endmodule

// ==== design/controlFsm.sv ====
`timescale 1ns/1ps

module controlFsm (
	input logic clk,
	input logic reset,
	input cpuPkg::opcodeT opcode,
	input cpuPkg::stackOpT stackOp,
	input logic [1:0] aluField,
	input cpuPkg::flagsT flags,
	input logic memDone,
	output logic memStart,
	output logic memWrite,
	output logic irLoad,
	output logic pcLoad,
	output logic spLoad,
	output logic regLoad,
	output logic yLoad,
	output logic flagLoad,
	output cpuPkg::aluOpT aluOp,
	output cpuPkg::xSelT xSel,
	output cpuPkg::ySelT ySel,
	output logic addrSel
);
	import cpuPkg::*;

	typedef enum logic [3:0] {
		sFetch, sFetchWait, sDecode, sPushDec, sWrite, sWriteWait, sCallJump,
		sPopRead, sPopWait, sPopLoad, sAluLoadY, sAluExec, sRetLoad
	} stateT;

	stateT state;
	stateT nextState;
	logic branchTaken;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) state <= sFetch;
		else state <= nextState;
	end

	// Branch condition from the stored flags
	always_comb begin
		case (opcode)
			opBrAlways: branchTaken = 1'b1;
			opBrCarry: branchTaken = flags.carry;
			opBrNoCarry: branchTaken = !flags.carry;
			opBrZero: branchTaken = flags.zero;
			opBrNoZero: branchTaken = !flags.zero;
			opBrOvf: branchTaken = flags.overflow;
			opBrNoOvf: branchTaken = !flags.overflow;
			opBrSign: branchTaken = flags.sign;
			opBrNoSign: branchTaken = !flags.sign;
			default: branchTaken = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////
	// Sequencing and datapath controls
	////////////////////////////////////////////////////////////////////
	always_comb begin
		nextState = state;
		memStart = 1'b0;
		memWrite = 1'b0;
		irLoad = 1'b0;
		pcLoad = 1'b0;
		spLoad = 1'b0;
		regLoad = 1'b0;
		yLoad = 1'b0;
		flagLoad = 1'b0;
		aluOp = aluPassY;
		xSel = xSelPc;
		ySel = ySelY;
		addrSel = 1'b0;
		case (state)
			sFetch: begin
				memStart = 1'b1;
				nextState = sFetchWait;
			end
			// PC+1 goes through the ALU as IR is loaded
			sFetchWait: if (memDone) begin
				irLoad = 1'b1;
				pcLoad = 1'b1;
				aluOp = aluIncX;
				nextState = sDecode;
			end
			sDecode: begin
				nextState = sFetch;
				if (opcode == opStack) begin
					nextState = (stackOp == stPush) ? sPushDec : sPopRead;
				end else if (opcode == opCall) begin
					nextState = sPushDec;
				end else if (branchTaken) begin
					pcLoad = 1'b1;
					ySel = ySelOffset;
					aluOp = aluAdd;
				end
			end
			sPushDec: begin
				spLoad = 1'b1;
				xSel = xSelSp;
				aluOp = aluDecX;
				nextState = sWrite;
			end
			sWrite: begin
				memStart = 1'b1;
				memWrite = 1'b1;
				addrSel = 1'b1;
				nextState = sWriteWait;
			end
			sWriteWait: if (memDone) begin
				nextState = (opcode == opCall) ? sCallJump : sFetch;
			end
			sCallJump: begin
				pcLoad = 1'b1;
				ySel = ySelOffset;
				aluOp = aluAdd;
				nextState = sFetch;
			end
			sPopRead: begin
				memStart = 1'b1;
				addrSel = 1'b1;
				nextState = sPopWait;
			end
			sPopWait: if (memDone) begin
				spLoad = 1'b1;
				xSel = xSelSp;
				aluOp = aluIncX;
				case (stackOp)
					stPop: nextState = sPopLoad;
					stAluStack: nextState = sAluLoadY;
					default: nextState = sRetLoad;
				endcase
			end
			sPopLoad: begin
				regLoad = 1'b1;
				ySel = ySelMem;
				nextState = sFetch;
			end
			sAluLoadY: begin
				yLoad = 1'b1;
				ySel = ySelMem;
				nextState = sAluExec;
			end
			// Function comes straight from IR[9:8]
			sAluExec: begin
				regLoad = 1'b1;
				flagLoad = 1'b1;
				xSel = xSelReg;
				aluOp = aluOpT'({1'b0, aluField});
				nextState = sFetch;
			end
			sRetLoad: begin
				pcLoad = 1'b1;
				ySel = ySelMem;
				nextState = sFetch;
			end
			default: nextState = sFetch;
		endcase
	end

endmodule

// ==== design/datapath.sv ====
`timescale 1ns/1ps

module datapath (
	input logic clk,
	input logic reset,
	input logic irLoad,
	input logic pcLoad,
	input logic spLoad,
	input logic regLoad,
	input logic yLoad,
	input logic flagLoad,
	input cpuPkg::aluOpT aluOp,
	input cpuPkg::xSelT xSel,
	input cpuPkg::ySelT ySel,
	input logic addrSel,
	input cpuPkg::word memData,
	output cpuPkg::word memAddr,
	output cpuPkg::word memWdata,
	output cpuPkg::opcodeT opcode,
	output cpuPkg::stackOpT stackOp,
	output logic [1:0] aluField,
	output cpuPkg::flagsT flags
);
	import cpuPkg::*;

	word pc;
	word sp;
	word ir;
	word yReg;
	word regData;
	word offset;
	word aluX;
	word aluY;
	word aluResult;
	flagsT aluFlags;

	////////////////////////////////////////////////////////////////////
	// Architectural registers
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= resetPc;
			sp <= stackTop;
			ir <= '0;
			flags <= '0;
		end else begin
			if (pcLoad) pc <= aluResult;
			if (spLoad) sp <= aluResult;
			if (irLoad) ir <= memData;
			if (flagLoad) flags <= aluFlags;
		end
	end

	// Y only ever holds a popped operand
	always_ff @(posedge clk) begin
		if (yLoad) yReg <= aluResult;
	end

	// Instruction fields
	assign opcode = opcodeT'(ir[15:12]);
	assign stackOp = stackOpT'(ir[11:10]);
	assign aluField = ir[9:8];
	assign offset = {{(dataWidth-12){ir[11]}}, ir[11:0]};

	// Operand multiplexers
	always_comb begin
		case (xSel)
			xSelSp: aluX = sp;
			xSelReg: aluX = regData;
			default: aluX = pc;
		endcase
		case (ySel)
			ySelMem: aluY = memData;
			ySelOffset: aluY = offset;
			default: aluY = yReg;
		endcase
	end

	// Stack accesses use SP, fetches use PC
	assign memAddr = addrSel ? sp : pc;
	assign memWdata = (opcode == opCall) ? pc : regData;

	registerFile u_registerFile (
		.clk(clk),
		.reset(reset),
		.wen(regLoad),
		.windex(ir[7:5]),
		.wdata(aluResult),
		.rindex(ir[7:5]),
		.rdata(regData)
	);

	alu u_alu (
		.x(aluX),
		.y(aluY),
		.op(aluOp),
		.result(aluResult),
		.flags(aluFlags)
	);

endmodule

// ==== design/memPort.sv ====
`timescale 1ns/1ps

module memPort (
	input logic clk,
	input logic reset,
	input logic memStart,
	input logic memWrite,
	input cpuPkg::word addr,
	input cpuPkg::word wdata,
	input logic memAck,
	input cpuPkg::word memRdata,
	output logic memReq,
	output logic memWriteOut,
	output logic memDone,
	output cpuPkg::word memAddr,
	output cpuPkg::word memWdata,
	output cpuPkg::word rdata
);
	typedef enum logic [1:0] {portIdle, portRequest, portRelease} portStateT;

	portStateT state;

	////////////////////////////////////////////////////////////////////
	// Four-phase handshake
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= portIdle;
			memReq <= 1'b0;
			memWriteOut <= 1'b0;
			memDone <= 1'b0;
		end else begin
			memDone <= 1'b0;
			case (state)
				portIdle: if (memStart) begin
					memReq <= 1'b1;
					memWriteOut <= memWrite;
					state <= portRequest;
				end
				portRequest: if (memAck) begin
					memReq <= 1'b0;
					state <= portRelease;
				end
				// Wait for the memory to drop its ack before finishing
				portRelease: if (!memAck) begin
					memWriteOut <= 1'b0;
					memDone <= 1'b1;
					state <= portIdle;
				end
				default: state <= portIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == portIdle && memStart) begin
			memAddr <= addr;
			memWdata <= wdata;
		end
		if (state == portRequest && memAck) begin
			rdata <= memRdata;
		end
	end

endmodule

// ==== design/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic reset,
	input logic wen,
	input cpuPkg::regIndex windex,
	input cpuPkg::word wdata,
	input cpuPkg::regIndex rindex,
	output cpuPkg::word rdata
);
	import cpuPkg::*;

	word regs [regCount];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wen) begin
			regs[windex] <= wdata;
		end
	end

	// Asynchronous read port
	assign rdata = regs[rindex];

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
	input cpuPkg::word x,
	input cpuPkg::word y,
	input cpuPkg::aluOpT op,
	output cpuPkg::word result,
	output cpuPkg::flagsT flags
);
	import cpuPkg::*;

	logic [dataWidth:0] sum;

	// Extra bit catches the carry out of the adder
	assign sum = {1'b0, x} + {1'b0, y};

	always_comb begin
		flags.carry = 1'b0;
		flags.overflow = 1'b0;
		case (op)
			aluAdd: begin
				result = sum[dataWidth-1:0];
				flags.carry = sum[dataWidth];
				// Same-sign operands giving a result of the other sign
				flags.overflow = (x[dataWidth-1] == y[dataWidth-1]) &&
					(sum[dataWidth-1] != x[dataWidth-1]);
			end
			aluNeg: result = -y;
			aluOr: result = x | y;
			aluNot: result = ~y;
			aluIncX: result = x + 1'b1;
			aluDecX: result = x - 1'b1;
			default: result = y;
		endcase
		flags.sign = result[dataWidth-1];
		flags.zero = (result == '0);
	end

endmodule

// ==== design/cpuPkg.sv ====
package cpuPkg;

	localparam int dataWidth = 16;
	localparam int regCount = 8;

	typedef logic [dataWidth-1:0] word;
	typedef logic [$clog2(regCount)-1:0] regIndex;

	// Opcode in IR[15:12], codes 0 and B..E do nothing
	typedef enum logic [3:0] {
		opNop       = 4'h0,
		opBrAlways  = 4'h1,
		opBrCarry   = 4'h2,
		opBrNoCarry = 4'h3,
		opBrZero    = 4'h4,
		opBrNoZero  = 4'h5,
		opBrOvf     = 4'h6,
		opBrNoOvf   = 4'h7,
		opBrSign    = 4'h8,
		opBrNoSign  = 4'h9,
		opCall      = 4'hA,
		opStack     = 4'hF
	} opcodeT;

	// Stack sub-operation in IR[11:10]
	typedef enum logic [1:0] {stPush, stPop, stAluStack, stRet} stackOpT;

	// Low two codes line up with IR[9:8]
	typedef enum logic [2:0] {
		aluAdd, aluNeg, aluOr, aluNot, aluIncX, aluDecX, aluPassY
	} aluOpT;

	typedef struct packed {
		logic sign;
		logic overflow;
		logic carry;
		logic zero;
	} flagsT;

	typedef enum logic [1:0] {xSelPc, xSelSp, xSelReg} xSelT;
	typedef enum logic [1:0] {ySelY, ySelMem, ySelOffset} ySelT;

	localparam word resetPc = 16'h0000;
	localparam word stackTop = 16'h0100;

endpackage
